// ==== rtl/alu.sv ====
// Combinational ALU; carry and overflow are set by ADD and SUB only, SUB carry is the borrow
`default_nettype none
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  aluOpcode  op,
    input  dataWord   operandA,
    input  dataWord   operandB,
    output dataWord   result,
    output flagVector flags
);
    logic [dataWidth:0] sum;            // Extra bit is the carry
    logic [dataWidth:0] difference;     // Extra bit is the borrow
    dataWord            shiftMagnitude;
    dataWord            shifted;
    logic               signA;
    logic               signB;

    assign signA = operandA[dataWidth-1];
    assign signB = operandB[dataWidth-1];

    assign sum            = {1'b0, operandA} + {1'b0, operandB};
    assign difference     = {1'b0, operandA} - {1'b0, operandB};
    assign shiftMagnitude = signB ? -operandB : operandB;

    // Positive amount shifts left, negative shifts right logically
    always_comb begin
        if (shiftMagnitude >= dataWord'(dataWidth)) begin
            shifted = '0;                                // Over range clears
        end else if (signB) begin
            shifted = operandA >> shiftMagnitude[3:0];
        end else begin
            shifted = operandA << shiftMagnitude[3:0];
        end
    end

    always_comb begin
        result = '0;
        flags  = '0;
        case (op)
            aluAdd: begin
                result              = sum[dataWidth-1:0];
                flags[flagCarry]    = sum[dataWidth];
                flags[flagOverflow] = (signA == signB) && (result[dataWidth-1] != signA);
            end
            aluSub: begin
                result              = difference[dataWidth-1:0];
                flags[flagCarry]    = difference[dataWidth];
                flags[flagOverflow] = (signA != signB) && (result[dataWidth-1] != signA);
            end
            aluAnd:   result = operandA & operandB;
            aluOr:    result = operandA | operandB;
            aluXor:   result = operandA ^ operandB;
            aluMov:   result = operandB;
            aluShift: result = shifted;
            aluLui:   result = {operandB[7:0], 8'h00};   // Immediate into the upper byte
            default:  result = '0;
        endcase
        flags[flagLow]      = operandA < operandB;       // Unsigned compare
        flags[flagZero]     = (result == '0);
        flags[flagNegative] = result[dataWidth-1];
    end
endmodule

`default_nettype wire

// ==== rtl/controller.sv ====
// Multicycle FSM; 3 cycles per instruction, 4 for LOAD; unknown opcodes only advance the PC
`default_nettype none
`timescale 1ns/1ns

module controller import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset,
    ctrlIf.controller ctrl,
    input  logic [3:0] firstOp,
    input  condCode    condition,
    input  logic [3:0] extendedOp,
    input  flagVector  flags
);
    cpuState    state;
    cpuState    nextState;
    logic       condMet;        // Branch or jump is taken
    logic [3:0] arithCode;      // Arithmetic code from whichever field carries it
    logic       arithValid;
    aluOpcode   arithOp;
    logic       arithWrites;    // Result goes to Rdst
    logic       arithFlags;     // Result updates the flags
    logic       arithZext;      // Logic immediates are zero extended

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateFetch;
        end else begin
            state <= nextState;
        end
    end

    // Flags come from a CMP of Rdst minus Rsrc
    always_comb begin
        case (condition)
            condEq:  condMet = flags[flagZero];
            condNe:  condMet = !flags[flagZero];
            condGt:  condMet = !flags[flagZero] && (flags[flagNegative] == flags[flagOverflow]);
            condLt:  condMet = flags[flagNegative] != flags[flagOverflow];
            condUc:  condMet = 1'b1;
            default: condMet = 1'b0;                     // Undecoded codes never taken
        endcase
    end

    assign arithCode = (firstOp == opRegister) ? extendedOp : firstOp;

    always_comb begin
        arithValid  = 1'b1;
        arithOp     = aluAdd;
        arithWrites = 1'b1;
        arithFlags  = 1'b0;
        arithZext   = 1'b0;
        case (arithCode)
            opAdd: arithFlags = 1'b1;
            opSub: begin
                arithOp    = aluSub;
                arithFlags = 1'b1;
            end
            opCmp: begin
                arithOp     = aluSub;                    // Subtract for flags only
                arithFlags  = 1'b1;
                arithWrites = 1'b0;
            end
            opAnd: begin
                arithOp   = aluAnd;
                arithZext = 1'b1;
            end
            opOr: begin
                arithOp   = aluOr;
                arithZext = 1'b1;
            end
            opXor: begin
                arithOp   = aluXor;
                arithZext = 1'b1;
            end
            opMov: begin
                arithOp   = aluMov;
                arithZext = 1'b1;
            end
            default: arithValid = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.aluOp        = arithOp;
        ctrl.useImmediate = 1'b0;
        ctrl.zeroExtend   = 1'b0;
        ctrl.regWrite     = 1'b0;
        ctrl.flagSet      = 1'b0;
        ctrl.resultSel    = resAlu;
        ctrl.pcLoadInstr  = 1'b0;
        ctrl.pcIncrement  = 1'b0;
        ctrl.pcBranch     = 1'b0;
        ctrl.pcJump       = 1'b0;
        ctrl.memWrite     = 1'b0;
        ctrl.addrFromReg  = 1'b0;
        nextState         = stateFetch;
        case (state)
            stateFetch: nextState = stateDecode;         // Port A addresses the PC
            stateDecode: begin
                ctrl.pcLoadInstr = 1'b1;                 // Read data is the instruction now
                nextState        = stateExecute;
            end
            stateExecute: begin
                ctrl.pcIncrement = 1'b1;
                if (arithValid) begin
                    ctrl.useImmediate = (firstOp != opRegister);
                    ctrl.zeroExtend   = arithZext;
                    ctrl.regWrite     = arithWrites;
                    ctrl.flagSet      = arithFlags;
                end else if (firstOp == opLui) begin
                    ctrl.aluOp        = aluLui;
                    ctrl.useImmediate = 1'b1;
                    ctrl.zeroExtend   = 1'b1;
                    ctrl.regWrite     = 1'b1;
                end else if (firstOp == opShift && extendedOp == extLsh) begin
                    ctrl.aluOp    = aluShift;
                    ctrl.regWrite = 1'b1;
                end else if (firstOp == opMemJump) begin
                    case (extendedOp)
                        extLoad: begin
                            ctrl.addrFromReg = 1'b1;
                            nextState        = stateWriteback;
                        end
                        extStor: begin
                            ctrl.addrFromReg = 1'b1;
                            ctrl.memWrite    = 1'b1;
                        end
                        extJump: begin
                            ctrl.pcJump      = condMet;
                            ctrl.pcIncrement = !condMet;
                        end
                        default: ctrl.memWrite = 1'b0;   // Undecoded, PC advances only
                    endcase
                end else if (firstOp == opBranch) begin
                    ctrl.pcBranch    = condMet;
                    ctrl.pcIncrement = !condMet;
                end
            end
            stateWriteback: begin
                ctrl.regWrite  = 1'b1;                   // LOAD data arrived last cycle
                ctrl.resultSel = resMemory;
            end
            stateMemory: nextState = stateFetch;         // No instruction enters it
            default:     nextState = stateFetch;
        endcase
    end
endmodule

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
// Widths, encodings and enums of the 16-bit CPU subset; only EQ, NE, GT, LT and UC are decoded
`default_nettype none

package cpuPkg;
    localparam int dataWidth = 16;                // Data word and register width
    localparam int addrWidth = 13;                // Word address width
    localparam int memDepth  = 1 << addrWidth;    // 8K words

    typedef logic [dataWidth-1:0] dataWord;
    typedef logic [addrWidth-1:0] memAddr;
    typedef logic [3:0]           regIndex;
    typedef logic [4:0]           flagVector;

    // Flag bit positions
    localparam int flagCarry    = 0;              // Carry out of ADD, borrow of SUB
    localparam int flagLow      = 1;              // Unsigned A < B
    localparam int flagOverflow = 2;              // Signed overflow
    localparam int flagZero     = 3;
    localparam int flagNegative = 4;

    localparam memAddr ioAddress = 13'h1FFF;      // Port A sees I/O here

    // Top nibble of each instruction class
    // The arithmetic codes double as the extended op of the register form
    localparam logic [3:0] opRegister = 4'b0000;
    localparam logic [3:0] opAnd      = 4'b0001;
    localparam logic [3:0] opOr       = 4'b0010;
    localparam logic [3:0] opXor      = 4'b0011;
    localparam logic [3:0] opMemJump  = 4'b0100;  // LOAD, STOR and Jcond
    localparam logic [3:0] opAdd      = 4'b0101;
    localparam logic [3:0] opShift    = 4'b1000;
    localparam logic [3:0] opSub      = 4'b1001;
    localparam logic [3:0] opCmp      = 4'b1011;
    localparam logic [3:0] opBranch   = 4'b1100;
    localparam logic [3:0] opMov      = 4'b1101;
    localparam logic [3:0] opLui      = 4'b1111;

    // Extended op within opShift and opMemJump
    localparam logic [3:0] extLsh  = 4'b0100;
    localparam logic [3:0] extLoad = 4'b0000;
    localparam logic [3:0] extStor = 4'b0100;
    localparam logic [3:0] extJump = 4'b1100;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluMov, aluShift, aluLui
    } aluOpcode;

    typedef enum logic {resAlu, resMemory} resultSelect;

    typedef enum logic [2:0] {
        stateFetch, stateDecode, stateExecute, stateMemory, stateWriteback
    } cpuState;

    typedef enum logic [3:0] {
        condEq = 4'b0000, condNe = 4'b0001, condGt = 4'b0110,
        condLt = 4'b1100, condUc = 4'b1110
    } condCode;
endpackage

`default_nettype wire

// ==== rtl/ctrlIf.sv ====
// Control bundle from the FSM; combinational, so each field holds only for the current state
`default_nettype none
`timescale 1ns/1ns

interface ctrlIf import cpuPkg::*; ();
    aluOpcode    aluOp;         // ALU function
    logic        useImmediate;  // Operand B from the immediate field
    logic        zeroExtend;    // Immediate zero extended, else sign extended
    logic        regWrite;      // Write Rdst
    logic        flagSet;       // Capture ALU flags
    resultSelect resultSel;     // Writeback source
    logic        pcLoadInstr;   // Latch the fetched word into the IR
    logic        pcIncrement;
    logic        pcBranch;      // PC plus displacement
    logic        pcJump;        // PC from Rsrc
    logic        memWrite;      // Port A write
    logic        addrFromReg;   // Port A address is Rsrc, else PC

    modport controller (
        output aluOp, useImmediate, zeroExtend, regWrite, flagSet, resultSel,
        output pcLoadInstr, pcIncrement, pcBranch, pcJump, memWrite, addrFromReg
    );

    modport datapath (
        input aluOp, useImmediate, zeroExtend, regWrite, flagSet, resultSel,
        input pcLoadInstr, pcIncrement, pcBranch, pcJump, addrFromReg
    );
endinterface

`default_nettype wire

// ==== rtl/datapath.sv ====
// PC, IR and flags; address and branch arithmetic wrap at 13 bits, the upper Rsrc bits are dropped
`default_nettype none
`timescale 1ns/1ns

module datapath import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    ctrlIf.datapath    ctrl,
    output logic [3:0] firstOp,
    output condCode    condition,
    output logic [3:0] extendedOp,
    output flagVector  flags,
    output memAddr     memAddrA,
    output dataWord    memWriteDataA,
    input  dataWord    memReadDataA
);
    memAddr    pc;
    dataWord   instruction;
    dataWord   rdstValue;       // Register named in bits 11:8
    dataWord   rsrcValue;       // Register named in bits 3:0
    dataWord   immediate;
    dataWord   operandB;
    dataWord   aluResult;
    dataWord   writeData;
    flagVector aluFlags;
    memAddr    branchTarget;

    assign firstOp    = instruction[15:12];
    assign condition  = condCode'(instruction[11:8]);
    assign extendedOp = instruction[7:4];

    assign immediate = ctrl.zeroExtend ? {8'h00, instruction[7:0]}
                                       : {{8{instruction[7]}}, instruction[7:0]};
    assign operandB  = ctrl.useImmediate ? immediate : rsrcValue;
    assign writeData = (ctrl.resultSel == resMemory) ? memReadDataA : aluResult;

    // PC still holds the branch's own address during EXECUTE
    assign branchTarget = pc + {{5{instruction[7]}}, instruction[7:0]};

    assign memAddrA      = ctrl.addrFromReg ? rsrcValue[addrWidth-1:0] : pc;
    assign memWriteDataA = rdstValue;                    // STOR data in bits 11:8

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            instruction <= '0;
            flags       <= '0;
        end else begin
            if (ctrl.pcLoadInstr) instruction <= memReadDataA;
            if (ctrl.flagSet)     flags       <= aluFlags;
            if (ctrl.pcBranch) begin
                pc <= branchTarget;
            end else if (ctrl.pcJump) begin
                pc <= rsrcValue[addrWidth-1:0];
            end else if (ctrl.pcIncrement) begin
                pc <= pc + 1'b1;
            end
        end
    end

    registerFile regs (
        .clk        (clk),
        .reset      (reset),
        .readIndexA (instruction[11:8]),
        .readIndexB (instruction[3:0]),
        .readDataA  (rdstValue),
        .readDataB  (rsrcValue),
        .writeEnable(ctrl.regWrite),
        .writeIndex (instruction[11:8]),
        .writeData  (writeData)
    );

    alu aluUnit (
        .op      (ctrl.aluOp),
        .operandA(rdstValue),
        .operandB(operandB),
        .result  (aluResult),
        .flags   (aluFlags)
    );
endmodule

`default_nettype wire

// ==== rtl/generalCpu.sv ====
// CPU top; hold reset high while loading through port B, port B reads lag the address by one cycle
`default_nettype none
`timescale 1ns/1ns

module generalCpu import cpuPkg::*; (
    input  logic    clk,            // System clock
    input  logic    reset,          // Synchronous, active high
    input  dataWord memData,        // Port B write data
    input  memAddr  addr,           // Port B address
    input  dataWord ioInput,
    input  logic    writeEnable,    // Port B write
    output dataWord memOutput,      // Port B read data
    output dataWord ioOutput
);
    ctrlIf ctrlBus ();

    logic [3:0] firstOp;
    logic [3:0] extendedOp;
    condCode    condition;
    flagVector  flags;
    memAddr     memAddrA;
    dataWord    memWriteDataA;
    dataWord    memReadDataA;

    controller cntrl (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrlBus.controller),
        .firstOp   (firstOp),
        .condition (condition),
        .extendedOp(extendedOp),
        .flags     (flags)
    );

    datapath dp (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrlBus.datapath),
        .firstOp      (firstOp),
        .condition    (condition),
        .extendedOp   (extendedOp),
        .flags        (flags),
        .memAddrA     (memAddrA),
        .memWriteDataA(memWriteDataA),
        .memReadDataA (memReadDataA)
    );

    memory mem (
        .clk         (clk),
        .reset       (reset),
        .addrA       (memAddrA),
        .writeDataA  (memWriteDataA),
        .writeEnableA(ctrlBus.memWrite),
        .readDataA   (memReadDataA),
        .addrB       (addr),
        .writeDataB  (memData),
        .writeEnableB(writeEnable),
        .readDataB   (memOutput),
        .ioInput     (ioInput),
        .ioOutput    (ioOutput)
    );
endmodule

`default_nettype wire

// ==== rtl/memory.sv ====
// Dual-port RAM, one-cycle reads on both ports; I/O mapping is on port A only, port A wins collisions
`default_nettype none
`timescale 1ns/1ns

module memory import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  memAddr  addrA,
    input  dataWord writeDataA,
    input  logic    writeEnableA,
    output dataWord readDataA,
    input  memAddr  addrB,
    input  dataWord writeDataB,
    input  logic    writeEnableB,
    output dataWord readDataB,
    input  dataWord ioInput,
    output dataWord ioOutput
);
    dataWord ram [memDepth];
    logic    ioSelA;            // Port A addresses the I/O word

    assign ioSelA = (addrA == ioAddress);

    always_ff @(posedge clk) begin
        if (writeEnableB) ram[addrB] <= writeDataB;
        if (writeEnableA && !ioSelA) ram[addrA] <= writeDataA;   // Later write takes effect
        readDataA <= ioSelA ? ioInput : ram[addrA];
        readDataB <= ram[addrB];                                 // RAM contents even at ioAddress
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ioOutput <= '0;
        end else if (writeEnableA && ioSelA) begin
            ioOutput <= writeDataA;
        end
    end
endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
// Sixteen general registers; reads are combinational, so a write shows on the next cycle
`default_nettype none
`timescale 1ns/1ns

module registerFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIndex readIndexA,
    input  regIndex readIndexB,
    output dataWord readDataA,
    output dataWord readDataB,
    input  logic    writeEnable,
    input  regIndex writeIndex,
    input  dataWord writeData
);
    dataWord regs [16];

    assign readDataA = regs[readIndexA];
    assign readDataB = regs[readIndexB];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;                           // All registers start at zero
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end
endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbGeneralCpu -f src.f -o simGeneralCpu

./obj_dir/simGeneralCpu > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== src.f ====
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/memory.sv
rtl/datapath.sv
rtl/controller.sv
rtl/generalCpu.sv
testbench/generalCpu_chk.sv
testbench/tbGeneralCpu.sv

// ==== testbench/generalCpu_chk.sv ====
// Bound into generalCpu; watches FSM order, control exclusivity and reset values through hierarchy
`default_nettype none
`timescale 1ns/1ns

module generalCpu_chk import cpuPkg::*; (
    input logic      clk,
    input logic      reset,
    input cpuState   state,
    input logic      memWrite,
    input logic      regWrite,
    input memAddr    pc,
    input flagVector flags
);
    // No instruction uses the MEMORY state
    stateLegal: assert property (@(posedge clk) disable iff (reset)
        state inside {stateFetch, stateDecode, stateExecute, stateWriteback})
        else $error("controller state out of range");

    // A new instruction starts only after EXECUTE or WRITEBACK
    fetchOrder: assert property (@(posedge clk) disable iff (reset)
        (state == stateFetch && !$past(reset)) |->
        ($past(state) == stateExecute || $past(state) == stateWriteback))
        else $error("FETCH entered from the wrong state");

    writeExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && regWrite))
        else $error("memory and register write active together");

    resetValues: assert property (@(posedge clk)
        $past(reset) |-> (pc == '0 && flags == '0 && state == stateFetch))
        else $error("PC, flags or state not cleared by reset");
endmodule

bind generalCpu generalCpu_chk chk (
    .clk     (clk),
    .reset   (reset),
    .state   (cntrl.state),
    .memWrite(ctrlBus.memWrite),
    .regWrite(ctrlBus.regWrite),
    .pc      (dp.pc),
    .flags   (flags)
);

`default_nettype wire

// ==== testbench/tbGeneralCpu.sv ====
// Random program self-check; program must fit in 256 words, results land from 0x1000 upward
`default_nettype none
`timescale 1ns/1ns

module tbGeneralCpu import cpuPkg::*; ();
    logic        clk;
    logic        reset;
    logic [15:0] memData;
    logic [12:0] addr;
    logic [15:0] ioInput;
    logic        writeEnable;
    logic [15:0] memOutput;
    logic [15:0] ioOutput;

    logic [15:0] lfsr;
    logic [15:0] prog [256];
    logic [15:0] refMem [8192];
    logic [15:0] refRegs [16];
    logic        refZ, refN, refV;        // Only the flags a branch can test
    logic [15:0] refIo;
    logic [15:0] ioValue;
    int          progLen;
    int          resultCount;
    int          runLimit;
    int          loadErrors, memErrors, ioErrors;

    logic [3:0] arithCodes [6] = '{opAdd, opSub, opAnd, opOr, opXor, opMov};
    logic [7:0] amounts [7]    = '{8'd3, 8'hFB, 8'd15, 8'hF0, 8'd20, 8'hEF, 8'd0};
    logic [3:0] conds [6]      = '{4'h0, 4'h1, 4'h6, 4'hC, 4'hE, 4'h2};

    generalCpu i_dut (
        .clk        (clk),
        .reset      (reset),
        .memData    (memData),
        .addr       (addr),
        .ioInput    (ioInput),
        .writeEnable(writeEnable),
        .memOutput  (memOutput),
        .ioOutput   (ioOutput)
    );

    always #5 clk = ~clk;                 // 10 ns period

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] rand8();
        logic [15:0] t;
        t = randBits(8);
        return t[7:0];
    endfunction

    function automatic logic [3:0] pickReg();
        logic [15:0] t;
        t = randBits(3);
        return 4'd2 + t[3:0];             // r2 to r9 hold random operands
    endfunction

    function automatic logic [15:0] encodeImm(input logic [3:0] op, rd, input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic logic [15:0] encodeReg(input logic [3:0] code, rd, rs);
        return {opRegister, rd, code, rs};
    endfunction

    task automatic emit(input logic [15:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic storeResult(input logic [3:0] r);
        emit({opMemJump, r, extStor, 4'd1});       // Store at r1
        emit(encodeImm(opAdd, 4'd1, 8'h01));       // Bump the result pointer
        resultCount++;
    endtask

    task automatic buildProgram();
        logic [3:0] ra;
        logic [3:0] rb;
        logic [7:0] m1;
        logic [7:0] m2;
        logic [15:0] t;
        progLen = 0;
        resultCount = 0;
        emit(encodeImm(opLui, 4'd1, 8'h10));       // r1 = 0x1000
        for (int r = 2; r < 10; r++) begin
            emit(encodeImm(opLui, 4'(r), rand8()));
            emit(encodeImm(opOr, 4'(r), rand8()));
        end
        for (int i = 0; i < 6; i++) begin
            for (int form = 0; form < 2; form++) begin
                emit(encodeReg(opMov, 4'd10, pickReg()));
                if (form == 0) emit(encodeReg(arithCodes[i], 4'd10, pickReg()));
                else emit(encodeImm(arithCodes[i], 4'd10, rand8()));
                storeResult(4'd10);
            end
        end
        for (int i = 0; i < 2; i++) begin
            emit(encodeImm(opLui, 4'd10, rand8()));
            storeResult(4'd10);
        end
        for (int i = 0; i < 7; i++) begin
            emit(encodeImm(opMov, 4'd11, 8'h00));
            emit(encodeImm(opAdd, 4'd11, amounts[i]));   // Sign extended amount
            emit(encodeReg(opMov, 4'd10, pickReg()));
            emit({opShift, 4'd10, extLsh, 4'd11});
            storeResult(4'd10);
        end
        for (int i = 0; i < 6; i++) begin
            for (int kind = 0; kind < 2; kind++) begin
                ra = pickReg();
                t = randBits(1);
                rb = t[0] ? ra : pickReg();              // Equal operands now and then
                m1 = rand8();
                m2 = m1 ^ 8'h5A;                         // Taken marker differs
                emit(encodeReg(opCmp, ra, rb));
                if (kind == 0) begin
                    emit({opBranch, conds[i], 8'd3});
                    emit(encodeImm(opMov, 4'd10, m1));
                    emit({opBranch, 4'hE, 8'd2});
                    emit(encodeImm(opMov, 4'd10, m2));
                end else begin
                    emit(encodeImm(opMov, 4'd10, m2));
                    emit(encodeImm(opMov, 4'd12, 8'(progLen + 3)));   // Jump over one word
                    emit({opMemJump, conds[i], extJump, 4'd12});
                    emit(encodeImm(opMov, 4'd10, m1));
                end
                storeResult(4'd10);
            end
        end
        for (int i = 0; i < 3; i++) begin
            emit(encodeImm(opLui, 4'd10, rand8()));
            emit(encodeImm(opOr, 4'd10, rand8()));
            emit({opMemJump, 4'd10, extStor, 4'd1});
            emit({opMemJump, 4'd13, extLoad, 4'd1});  // Read back the same word
            emit(encodeImm(opAdd, 4'd1, 8'h01));
            resultCount++;
            storeResult(4'd13);
        end
        emit(encodeImm(opLui, 4'd14, 8'h1F));
        emit(encodeImm(opOr, 4'd14, 8'hFF));          // r14 = I/O word
        emit({opMemJump, 4'd13, extLoad, 4'd14});
        storeResult(4'd13);
        t = randBits(6);
        emit(encodeImm(opAdd, 4'd13, 8'd1 + t[7:0]));
        emit({opMemJump, 4'd13, extStor, 4'd14});     // Last action drives ioOutput
        emit({opBranch, 4'hE, 8'h00});                // Halt, branch to itself
    endtask

    function automatic logic condTaken(input logic [3:0] c);
        case (c)
            4'h0:    return refZ;
            4'h1:    return !refZ;
            4'h6:    return !refZ && (refN == refV);   // Signed greater
            4'hC:    return refN != refV;              // Signed less
            4'hE:    return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic void refArith(input logic [3:0] rd, code, input logic [15:0] a, b);
        logic [15:0] r;
        logic        isArith;
        isArith = 1'b1;
        case (code)
            opAdd:        r = a + b;
            opSub, opCmp: r = a - b;
            opAnd: begin
                r = a & b;
                isArith = 1'b0;
            end
            opOr: begin
                r = a | b;
                isArith = 1'b0;
            end
            opXor: begin
                r = a ^ b;
                isArith = 1'b0;
            end
            opMov: begin
                r = b;
                isArith = 1'b0;
            end
            default: return;
        endcase
        if (isArith) begin
            refZ = (r == 16'h0);
            refN = r[15];
            if (code == opAdd) refV = (a[15] == b[15]) && (r[15] != a[15]);
            else refV = (a[15] != b[15]) && (r[15] != a[15]);
        end
        if (code != opCmp) refRegs[rd] = r;
    endfunction

    // ISA interpreter, runs up to the halt branch
    function automatic int refExecute();
        logic [12:0] pc, nextPc, ea;
        logic [15:0] ir, a, b, mag;
        logic [3:0]  op, code, rd;
        logic        done;
        int          steps;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            ir = refMem[pc];
            op = ir[15:12];
            rd = ir[11:8];
            a = refRegs[rd];
            b = refRegs[ir[3:0]];
            ea = b[12:0];
            nextPc = pc + 13'd1;
            steps++;
            if (op == opLui) begin
                refRegs[rd] = {ir[7:0], 8'h00};
            end else if (op == opShift && ir[7:4] == extLsh) begin
                mag = b[15] ? -b : b;
                if (mag >= 16'd16) refRegs[rd] = 16'h0;
                else if (b[15]) refRegs[rd] = a >> mag[3:0];
                else refRegs[rd] = a << mag[3:0];
            end else if (op == opMemJump) begin
                if (ir[7:4] == extLoad) begin
                    refRegs[rd] = (ea == 13'h1FFF) ? ioValue : refMem[ea];
                end else if (ir[7:4] == extStor) begin
                    if (ea == 13'h1FFF) refIo = a;
                    else refMem[ea] = a;
                end else if (ir[7:4] == extJump && condTaken(rd)) begin
                    nextPc = ea;
                end
            end else if (op == opBranch) begin
                if (condTaken(rd)) nextPc = pc + {{5{ir[7]}}, ir[7:0]};
                done = (nextPc == pc);
            end else begin
                code = (op == opRegister) ? ir[7:4] : op;
                if (op != opRegister) begin
                    if (code == opAdd || code == opSub || code == opCmp) b = {{8{ir[7]}}, ir[7:0]};
                    else b = {8'h00, ir[7:0]};
                end
                refArith(rd, code, a, b);
            end
            pc = nextPc;
        end
        return steps;
    endfunction

    task automatic readWord(input logic [12:0] a, output logic [15:0] d);
        @(posedge clk);
        addr <= a;
        @(posedge clk);                       // RAM registers the read here
        @(negedge clk);
        d = memOutput;
    endtask

    initial begin
        wait (runLimit != 0);
        repeat (runLimit) @(posedge clk);
        $display("Timeout, program did not finish within %0d cycles", runLimit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [15:0] got;
        clk = 1'b0;
        reset = 1'b1;
        memData = '0;
        addr = '0;
        ioInput = '0;
        writeEnable = 1'b0;
        lfsr = 16'd12853;
        runLimit = 0;
        loadErrors = 0;
        memErrors = 0;
        ioErrors = 0;
        refZ = 1'b0;
        refN = 1'b0;
        refV = 1'b0;
        refIo = '0;
        buildProgram();
        ioValue = randBits(15);                       // Bit 15 clear keeps the final ioOutput nonzero
        for (int i = 0; i < 8192; i++) refMem[i] = (i < progLen) ? prog[i] : 16'h0;
        for (int i = 0; i < 16; i++) refRegs[i] = '0;
        void'(refExecute());
        runLimit = progLen * 4 * 2 + progLen + resultCount * 2 + 100;
        repeat (2) @(posedge clk);
        ioInput <= ioValue;
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            addr <= 13'(i);
            memData <= prog[i];
            writeEnable <= 1'b1;
        end
        @(posedge clk);
        writeEnable <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            readWord(13'(i), got);
            if (got !== prog[i]) begin
                $display("ERR memOutput at %h: got %h expected %h", i, got, prog[i]);
                loadErrors++;
            end
        end
        if (ioOutput !== 16'h0) begin
            $display("ERR ioOutput after reset: got %h expected %h", ioOutput, 16'h0);
            loadErrors++;
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (ioOutput === 16'h0) @(negedge clk);  // Final store to the I/O word
        repeat (4) @(negedge clk);
        for (int i = 0; i < resultCount; i++) begin
            readWord(13'h1000 + 13'(i), got);
            if (got !== refMem[13'h1000 + 13'(i)]) begin
                $display("ERR memOutput at %h: got %h expected %h",
                         13'h1000 + 13'(i), got, refMem[13'h1000 + 13'(i)]);
                memErrors++;
            end
        end
        if (ioOutput !== refIo) begin
            $display("ERR ioOutput: got %h expected %h", ioOutput, refIo);
            ioErrors++;
        end
        $display("Errors: load %0d, results %0d, io %0d", loadErrors, memErrors, ioErrors);
        if (loadErrors + memErrors + ioErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire
